/* build.f */
+incdir+rtl
+incdir+sim
rtl/noc_route_pkg.sv
rtl/noc_flit_pkg.sv
rtl/input_port_if.sv
rtl/router_fifo.sv
rtl/lookahead_routing.sv
rtl/input_unit.sv
rtl/router_arbiter.sv
rtl/output_unit.sv
rtl/lookahead_router.sv
sim/tb_router.sv

/* rtl/input_port_if.sv */
////////////////////
// Input port view: queue head and routing shared with all outputs
////////////////////
interface input_port_if;
  import noc_route_pkg::*;
  import noc_flit_pkg::*;

  flit_t      head;
  logic       valid;
  // Head routing, or held routing while the body flows
  direction_t request;
  direction_t next_routing;
  // One read bit per output port
  logic [4:0] read;

  modport queue (output head, valid, request, next_routing, input read);
  modport switch (input head, valid, request, next_routing, output read);
endinterface

/* rtl/input_unit.sv */
////////////////////
// Input port: queue, held routing request, look-ahead routing
////////////////////
module input_unit (
  input  logic                clk,
  input  logic                rst,
  input  noc_route_pkg::xy_t  position_i,
  input  noc_flit_pkg::flit_t data_i,
  input  logic                data_void_i,
  output logic                stop_o,
  input_port_if.queue         port
);
  import noc_route_pkg::*;
  import noc_flit_pkg::*;

  flit_t      queue_head;
  logic       queue_empty;
  logic       queue_full;
  logic       valid_head;
  direction_t saved_request;

  // Any output taking the head pops the queue
  router_fifo input_queue_i (
    .clk,
    .rst,
    .wr_en_i (~data_void_i),
    .data_i  (data_i),
    .rd_en_i (|port.read),
    .data_o  (queue_head),
    .empty_o (queue_empty),
    .full_o  (queue_full)
  );

  assign port.head = queue_head;
  // Empty queue still offers a flit on the bypass path
  assign port.valid = ~(queue_empty & data_void_i);
  assign valid_head = port.valid & queue_head.header.preamble.head;

  // Worm routing kept until the tail reaches the head
  always_ff @(posedge clk) begin
    if (rst) begin
      saved_request <= '0;
    end else if (port.valid & queue_head.header.preamble.tail) begin
      saved_request <= '0;
    end else if (valid_head) begin
      saved_request <= queue_head.header.routing;
    end
  end

  assign port.request = valid_head ? queue_head.header.routing : saved_request;

  lookahead_routing lookahead_routing_i (
    .position_i        (position_i),
    .destination_i     (queue_head.header.info.destination),
    .current_routing_i (queue_head.header.routing),
    .next_routing_o    (port.next_routing)
  );

  // Stop the sender while the queue is full
  assign stop_o = queue_full;

endmodule

/* rtl/lookahead_router.sv */
////////////////////
// Five-port mesh router, XY look-ahead routing, wormhole, stop/void links
////////////////////
module lookahead_router (
  input  logic                                clk,
  input  logic                                rst,
  input  noc_route_pkg::xy_t                  position_i,
  // Input links
  input  logic [noc_flit_pkg::flit_width-1:0] data_n_i,
  input  logic [noc_flit_pkg::flit_width-1:0] data_s_i,
  input  logic [noc_flit_pkg::flit_width-1:0] data_w_i,
  input  logic [noc_flit_pkg::flit_width-1:0] data_e_i,
  input  logic [noc_flit_pkg::flit_width-1:0] data_p_i,
  input  logic [4:0]                          data_void_i,
  output logic [4:0]                          stop_o,
  // Output links
  output logic [noc_flit_pkg::flit_width-1:0] data_n_o,
  output logic [noc_flit_pkg::flit_width-1:0] data_s_o,
  output logic [noc_flit_pkg::flit_width-1:0] data_w_o,
  output logic [noc_flit_pkg::flit_width-1:0] data_e_o,
  output logic [noc_flit_pkg::flit_width-1:0] data_p_o,
  output logic [4:0]                          data_void_o,
  input  logic [4:0]                          stop_i
);
  import noc_route_pkg::*;
  import noc_flit_pkg::*;

  flit_t data_in [5];
  flit_t data_out [5];

  // One shared view per input, seen by every output
  input_port_if ports_if [5] ();

  assign data_in[north_port] = data_n_i;
  assign data_in[south_port] = data_s_i;
  assign data_in[west_port]  = data_w_i;
  assign data_in[east_port]  = data_e_i;
  assign data_in[local_port] = data_p_i;

  for (genvar p = 0; p < 5; p++) begin : gen_ports
    input_unit input_unit_i (
      .clk,
      .rst,
      .position_i,
      .data_i      (data_in[p]),
      .data_void_i (data_void_i[p]),
      .stop_o      (stop_o[p]),
      .port        (ports_if[p])
    );

    output_unit #(
      .out_port (port_e'(p))
    ) output_unit_i (
      .clk,
      .rst,
      .in_ports    (ports_if),
      .stop_i      (stop_i[p]),
      .data_o      (data_out[p]),
      .data_void_o (data_void_o[p])
    );
  end

  assign data_n_o = data_out[north_port];
  assign data_s_o = data_out[south_port];
  assign data_w_o = data_out[west_port];
  assign data_e_o = data_out[east_port];
  assign data_p_o = data_out[local_port];

endmodule

/* rtl/lookahead_routing.sv */
////////////////////
// XY route for the next hop of a head flit
////////////////////
module lookahead_routing (
  input  noc_route_pkg::xy_t        position_i,
  input  noc_route_pkg::xy_t        destination_i,
  input  noc_route_pkg::direction_t current_routing_i,
  output noc_route_pkg::direction_t next_routing_o
);
  import noc_route_pkg::*;

  xy_t next_position;

  // Coordinate of the router the flit enters after this one
  always_comb begin
    next_position = position_i;
    case (current_routing_i)
      go_north: next_position.y = position_i.y - 1'b1;
      go_south: next_position.y = position_i.y + 1'b1;
      go_west:  next_position.x = position_i.x - 1'b1;
      go_east:  next_position.x = position_i.x + 1'b1;
      default:  next_position = position_i;
    endcase
  end

  // X first, then Y, then eject
  always_comb begin
    if (current_routing_i == go_local) begin
      // Worm leaves the mesh here, nothing to look ahead to
      next_routing_o = current_routing_i;
    end else if (destination_i.x > next_position.x) begin
      next_routing_o = go_east;
    end else if (destination_i.x < next_position.x) begin
      next_routing_o = go_west;
    end else if (destination_i.y < next_position.y) begin
      next_routing_o = go_north;
    end else if (destination_i.y > next_position.y) begin
      next_routing_o = go_south;
    end else begin
      next_routing_o = go_local;
    end
  end

endmodule

/* rtl/noc_flit_pkg.sv */
////////////////////
// Flit types: preamble, header and worm state
////////////////////
`include "noc_settings.svh"

package noc_flit_pkg;

  // Head sits above tail; both set on a single-flit packet
  typedef struct packed {
    logic head;
    logic tail;
  } preamble_t;

  typedef struct packed {
    noc_route_pkg::xy_t source;
    noc_route_pkg::xy_t destination;
  } packet_info_t;

  // Padding between packet info and the routing field
  localparam int unsigned reserved_width =
    `NOC_DATA_WIDTH - $bits(packet_info_t) - $bits(noc_route_pkg::direction_t);

  // Full link width, preamble included
  localparam int unsigned flit_width = `NOC_DATA_WIDTH + $bits(preamble_t);

  // Routing lives in the lowest bits so it can be swapped in place
  typedef struct packed {
    preamble_t                 preamble;
    packet_info_t              info;
    logic [reserved_width-1:0] reserved;
    noc_route_pkg::direction_t routing;
  } header_t;

  typedef union packed {
    header_t               header;
    logic [flit_width-1:0] raw;
  } flit_t;

  // Worm progress at an output port
  typedef enum logic {
    head_flit     = 1'b0,
    payload_flits = 1'b1
  } flit_state_e;

endpackage

/* rtl/noc_route_pkg.sv */
////////////////////
// Routing types: port indices, one-hot directions, mesh coordinates
////////////////////
`include "noc_settings.svh"

package noc_route_pkg;

  // Port index order, shared by every per-port vector
  typedef enum logic [2:0] {
    north_port = 3'd0,
    south_port = 3'd1,
    west_port  = 3'd2,
    east_port  = 3'd3,
    local_port = 3'd4
  } port_e;

  // One-hot output request, one bit per port index
  typedef logic [4:0] direction_t;

  localparam direction_t go_north = 5'b00001;
  localparam direction_t go_south = 5'b00010;
  localparam direction_t go_west  = 5'b00100;
  localparam direction_t go_east  = 5'b01000;
  localparam direction_t go_local = 5'b10000;

  // Mesh coordinate
  // East is x+1, west x-1, north y-1, south y+1
  typedef struct packed {
    logic [`NOC_COORD_WIDTH-1:0] x;
    logic [`NOC_COORD_WIDTH-1:0] y;
  } xy_t;

endpackage

/* rtl/noc_settings.svh */
////////////////////
// NoC router settings
// Flit width, input queue depth and mesh coordinate width
////////////////////
`ifndef NOC_SETTINGS_SVH
`define NOC_SETTINGS_SVH

// Flit bits without the head/tail preamble
`define NOC_DATA_WIDTH 32
// Entries per input queue
`define NOC_QUEUE_DEPTH 4
// Bits per mesh coordinate
`define NOC_COORD_WIDTH 3

`endif

/* rtl/output_unit.sv */
////////////////////
// Output port: arbitration, worm FSM, crossbar, output register
////////////////////
module output_unit #(
  parameter noc_route_pkg::port_e out_port = noc_route_pkg::local_port
) (
  input  logic                clk,
  input  logic                rst,
  input_port_if.switch        in_ports [5],
  input  logic                stop_i,
  output noc_flit_pkg::flit_t data_o,
  output logic                data_void_o
);
  import noc_route_pkg::*;
  import noc_flit_pkg::*;

  flit_t       in_head [5];
  logic [4:0]  in_valid;
  direction_t  in_next_routing [5];
  logic [3:0]  request;
  logic [3:0]  grant;
  logic        grant_valid;
  logic [3:0]  config_now;
  logic [3:0]  config_saved;
  logic [4:0]  select;
  flit_state_e state;
  flit_state_e state_next;
  logic        forwarding;
  flit_t       sel_flit;
  logic        sel_valid;
  direction_t  sel_next_routing;
  flit_t       out_flit;
  logic        out_valid;
  logic        forwarding_head;
  logic        forwarding_tail;

  ////////////////////
  // Input gathering
  ////////////////////
  // Four-entry lists skip this port; select maps them back to five
  for (genvar i = 0; i < 5; i++) begin : gen_inputs
    assign in_head[i]                 = in_ports[i].head;
    assign in_valid[i]                = in_ports[i].valid;
    assign in_next_routing[i]         = in_ports[i].next_routing;
    assign in_ports[i].read[out_port] = select[i] & ~stop_i;
    if (i < out_port) begin : gen_below
      assign request[i] = in_ports[i].request[out_port];
      assign select[i]  = config_now[i];
    end else if (i > out_port) begin : gen_above
      assign request[i-1] = in_ports[i].request[out_port];
      assign select[i]    = config_now[i-1];
    end else begin : gen_self
      // No U-turns
      assign select[i] = 1'b0;
    end
  end

  router_arbiter arbiter_i (
    .clk,
    .rst,
    .request_i         (request),
    .forwarding_head_i (forwarding_head),
    .forwarding_tail_i (forwarding_tail),
    .grant_o           (grant),
    .grant_valid_o     (grant_valid)
  );

  ////////////////////
  // Worm FSM
  ////////////////////
  always_comb begin
    config_now = '0;
    forwarding = 1'b0;
    if (state == head_flit) begin
      // New worm may start only into a free link
      if (grant_valid & ~stop_i) begin
        config_now = grant;
        forwarding = 1'b1;
      end
    end else begin
      config_now = config_saved;
      forwarding = 1'b1;
    end
  end

  always_comb begin
    state_next = state;
    if (forwarding_tail) begin
      state_next = head_flit;
    end else if (forwarding_head) begin
      state_next = payload_flits;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= head_flit;
    end else begin
      state <= state_next;
    end
  end

  always_ff @(posedge clk) begin
    if (forwarding) begin
      config_saved <= config_now;
    end
  end

  ////////////////////
  // Crossbar
  ////////////////////
  always_comb begin
    sel_flit         = '0;
    sel_valid        = 1'b0;
    sel_next_routing = '0;
    for (int i = 0; i < 5; i++) begin
      if (select[i]) begin
        sel_flit         = in_head[i];
        sel_valid        = in_valid[i];
        sel_next_routing = in_next_routing[i];
      end
    end
  end

  // Head flit carries the next router's port on the way out
  always_comb begin
    out_flit = sel_flit;
    if (state == head_flit) begin
      out_flit.header.routing = sel_next_routing;
    end
  end

  assign out_valid       = forwarding & sel_valid;
  assign forwarding_head = out_valid & out_flit.header.preamble.head & ~stop_i;
  assign forwarding_tail = out_valid & out_flit.header.preamble.tail & ~stop_i;

  // Link register holds while the next router stops us
  always_ff @(posedge clk) begin
    if (rst) begin
      data_void_o <= 1'b1;
    end else if (~stop_i) begin
      data_void_o <= ~out_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (out_valid & ~stop_i) begin
      data_o <= out_flit;
    end
  end

endmodule

/* rtl/router_arbiter.sv */
////////////////////
// Round-robin arbiter over four inputs, grant held per worm
////////////////////
module router_arbiter (
  input  logic       clk,
  input  logic       rst,
  input  logic [3:0] request_i,
  input  logic       forwarding_head_i,
  input  logic       forwarding_tail_i,
  output logic [3:0] grant_o,
  output logic       grant_valid_o
);
  logic [1:0] priority_ptr;
  logic [1:0] winner;
  logic [3:0] pick;
  logic [3:0] held_grant;
  logic       locked;

  // Search from the priority pointer; the nearest requester wins
  always_comb begin
    logic [1:0] idx;
    pick   = '0;
    winner = priority_ptr;
    for (int k = 3; k >= 0; k--) begin
      idx = priority_ptr + 2'(k);
      if (request_i[idx]) begin
        pick      = '0;
        pick[idx] = 1'b1;
        winner    = idx;
      end
    end
  end

  // Frozen from head to tail
  assign grant_o       = locked ? held_grant : pick;
  assign grant_valid_o = |grant_o;

  always_ff @(posedge clk) begin
    if (rst) begin
      locked       <= 1'b0;
      priority_ptr <= '0;
    end else begin
      // Single-flit packets never lock
      if (forwarding_tail_i) begin
        locked <= 1'b0;
      end else if (forwarding_head_i) begin
        locked <= 1'b1;
      end
      // Winner drops to lowest priority once its head leaves
      if (forwarding_head_i) begin
        priority_ptr <= winner + 2'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (forwarding_head_i) begin
      held_grant <= pick;
    end
  end

endmodule

/* rtl/router_fifo.sv */
////////////////////
// Input queue, bypassed when empty
////////////////////
`include "noc_settings.svh"

module router_fifo (
  input  logic                clk,
  input  logic                rst,
  input  logic                wr_en_i,
  input  noc_flit_pkg::flit_t data_i,
  input  logic                rd_en_i,
  output noc_flit_pkg::flit_t data_o,
  output logic                empty_o,
  output logic                full_o
);
  import noc_flit_pkg::*;

  localparam int unsigned ptr_width = $clog2(`NOC_QUEUE_DEPTH);
  localparam logic [ptr_width-1:0] last_slot = ptr_width'(`NOC_QUEUE_DEPTH - 1);
  localparam logic [ptr_width:0] depth_count = (ptr_width + 1)'(`NOC_QUEUE_DEPTH);

  flit_t                mem [`NOC_QUEUE_DEPTH];
  logic [ptr_width-1:0] wr_ptr;
  logic [ptr_width-1:0] rd_ptr;
  logic [ptr_width:0]   count;
  logic                 bypass;
  logic                 push;
  logic                 pop;

  assign empty_o = count == '0;
  assign full_o  = count == depth_count;

  // Empty queue shows the incoming flit directly
  assign data_o = empty_o ? data_i : mem[rd_ptr];

  // Flit taken in the same cycle it arrives never gets stored
  assign bypass = empty_o & wr_en_i & rd_en_i;
  assign push   = wr_en_i & ~full_o & ~bypass;
  assign pop    = rd_en_i & ~empty_o;

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= data_i;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == last_slot) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == last_slot) ? '0 : rd_ptr + 1'b1;
      end
      if (push & ~pop) begin
        count <= count + 1'b1;
      end else if (pop & ~push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

/* run_sim.sh */
#!/bin/sh
# Build the router testbench with Verilator, run it, scan the log
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing -f build.f --top-module tb_router -Mdir obj_dir -o tb_router
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_router > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q ">>> FAIL" "$log"; then
  exit 1
fi
exit 0

/* sim/tb_router_tasks.svh */
////////////////////
// Directed router tests with flit build, send and compare helpers
////////////////////
`ifndef TB_ROUTER_TASKS_SVH
`define TB_ROUTER_TASKS_SVH

function automatic string port_name(input int p);
  case (p)
    n_port:  return "data_n_o";
    s_port:  return "data_s_o";
    w_port:  return "data_w_o";
    e_port:  return "data_e_o";
    default: return "data_p_o";
  endcase
endfunction

function automatic logic [4:0] one_hot(input int p);
  return 5'b00001 << p;
endfunction

// XY pick of the router one hop past this one
// East x+1, west x-1, north y-1, south y+1
function automatic logic [4:0] expected_route(input int route_port, input int dst_x,
                                              input int dst_y);
  int nx;
  int ny;
  nx = pos_x;
  ny = pos_y;
  if (route_port == l_port) begin
    return one_hot(l_port);
  end
  if (route_port == e_port) nx = nx + 1;
  if (route_port == w_port) nx = nx - 1;
  if (route_port == n_port) ny = ny - 1;
  if (route_port == s_port) ny = ny + 1;
  if (dst_x != nx) begin
    return one_hot(dst_x > nx ? e_port : w_port);
  end
  if (dst_y != ny) begin
    return one_hot(dst_y > ny ? s_port : n_port);
  end
  return one_hot(l_port);
endfunction

function automatic int outstanding();
  int total;
  total = 0;
  for (int p = 0; p < 5; p++) begin
    total += expected_q[p].size();
  end
  return total;
endfunction

// Stage a worm on an input and queue what its output should deliver
task automatic build_worm(input int in_port, input int route_port, input int dst_x,
                          input int dst_y, input int len);
  logic [flit_w-1:0]    flit;
  logic [4*coord_w-1:0] info;
  logic [rsv_w-1:0]     reserved;
  // Source coordinate carries the input index
  info     = {coord_w'(in_port), coord_w'(in_port), coord_w'(dst_x), coord_w'(dst_y)};
  reserved = rsv_w'($urandom());
  flit     = {1'b1, (len == 1), info, reserved, one_hot(route_port)};
  staged_q[in_port].push_back(flit);
  // Only the head's routing changes on the way out
  flit[4:0] = expected_route(route_port, dst_x, dst_y);
  expected_q[route_port].push_back(flit);
  for (int i = 1; i < len; i++) begin
    flit = {1'b0, (i == len - 1), data_w'($urandom())};
    staged_q[in_port].push_back(flit);
    expected_q[route_port].push_back(flit);
  end
endtask

task automatic next_drive();
  @(posedge clk);
  #0.5;
endtask

task automatic idle_link(input int p);
  next_drive();
  data_void_i[p] = 1'b1;
endtask

// Flit stays on the link until a cycle with stop low takes it
task automatic send_flit(input int p, input logic [flit_w-1:0] flit);
  logic taken;
  taken = 1'b0;
  while (!taken) begin
    next_drive();
    link_data[p]   = flit;
    data_void_i[p] = 1'b0;
    taken          = !stop_o[p];
  end
endtask

task automatic send_staged(input int p);
  while (staged_q[p].size() != 0) begin
    send_flit(p, staged_q[p].pop_front());
  end
  idle_link(p);
endtask

task automatic compare_arrivals();
  for (int p = 0; p < 5; p++) begin
    while (seen_count[p] < got_q[p].size()) begin
      if (expected_q[p].size() == 0) begin
        error_count++;
        $display("Output %s delivered a flit that no test sent", port_name(p));
      end else begin
        check_value(port_name(p), got_q[p][seen_count[p]], expected_q[p].pop_front());
      end
      seen_count[p]++;
    end
  end
endtask

task automatic wait_drained(input int budget);
  int waited;
  waited = 0;
  while (outstanding() != 0 && waited < budget) begin
    next_drive();
    waited++;
    compare_arrivals();
  end
  if (outstanding() != 0) begin
    error_count++;
    $display("Gave up after %0d cycles with %0d flits never delivered", budget, outstanding());
  end
  // Late extras still get caught
  repeat (2) next_drive();
  compare_arrivals();
endtask

task automatic finish_test(input string name, input int errors_before);
  test_count++;
  if (error_count == errors_before) begin
    $display("Test %0d %s: ok", test_count, name);
  end else begin
    $display("Test %0d %s: %0d errors", test_count, name, error_count - errors_before);
  end
endtask

////////////////////
// Tests
////////////////////
task automatic idle_after_reset();
  int errors_before;
  errors_before = error_count;
  check_value("data_void_o", flit_w'(data_void_o), flit_w'(5'h1f));
  check_value("stop_o", flit_w'(stop_o), '0);
  finish_test("reset_state", errors_before);
endtask

task automatic single_flit_routing();
  int errors_before;
  errors_before = error_count;
  build_worm(l_port, e_port, 4, 2, 1);
  send_staged(l_port);
  // Idle path puts the packet on east one edge after it was taken
  check_value("data_void_o[east]", flit_w'(data_void_o[e_port]), '0);
  build_worm(l_port, e_port, 3, 1, 1);
  send_staged(l_port);
  // Next router 2,1 is the destination, so the head leaves north carrying local
  build_worm(l_port, n_port, 2, 1, 1);
  send_staged(l_port);
  wait_drained(3 * cycles_per_flit + test_margin);
  finish_test("single_flit", errors_before);
endtask

task automatic worm_in_order();
  int errors_before;
  errors_before = error_count;
  build_worm(w_port, s_port, 2, 5, 6);
  send_staged(w_port);
  wait_drained(6 * cycles_per_flit + test_margin);
  finish_test("worm_in_order", errors_before);
endtask

task automatic local_contention();
  int errors_before;
  errors_before = error_count;
  // Local arbiter still has its reset priority so north wins the tie
  build_worm(n_port, l_port, pos_x, pos_y, 5);
  build_worm(w_port, l_port, pos_x, pos_y, 5);
  fork
    send_staged(n_port);
    send_staged(w_port);
  join
  wait_drained(10 * cycles_per_flit + test_margin);
  finish_test("contention", errors_before);
endtask

task automatic east_back_pressure();
  int errors_before;
  errors_before = error_count;
  stop_i[e_port] = 1'b1;
  build_worm(l_port, e_port, 5, 2, 8);
  repeat (depth) send_flit(l_port, staged_q[l_port].pop_front());
  idle_link(l_port);
  check_value("stop_o[local]", flit_w'(stop_o[l_port]), flit_w'(1'b1));
  fork
    send_staged(l_port);
    begin
      repeat (6) next_drive();
      check_value("stop_o[local]", flit_w'(stop_o[l_port]), flit_w'(1'b1));
      check_value("data_void_o[east]", flit_w'(data_void_o[e_port]), flit_w'(1'b1));
      stop_i[e_port] = 1'b0;
    end
  join
  wait_drained(8 * cycles_per_flit + test_margin);
  finish_test("back_pressure", errors_before);
endtask

task automatic crossing_worms();
  int errors_before;
  errors_before = error_count;
  build_worm(n_port, s_port, 2, 4, 6);
  build_worm(e_port, w_port, 0, 2, 6);
  fork
    send_staged(n_port);
    send_staged(e_port);
  join
  wait_drained(12 * cycles_per_flit + test_margin);
  finish_test("parallel_worms", errors_before);
endtask

`endif

/* sim/tb_router.sv */
////////////////////
// Router testbench with clock, reset, DUT, link monitor and summary
////////////////////
`include "noc_settings.svh"

module tb_router;
  timeunit 1ns;
  timeprecision 100ps;
  import noc_route_pkg::*;

  localparam int data_w  = `NOC_DATA_WIDTH;
  localparam int flit_w  = `NOC_DATA_WIDTH + 2;
  localparam int coord_w = `NOC_COORD_WIDTH;
  localparam int depth   = `NOC_QUEUE_DEPTH;
  // Header padding between packet info and routing
  localparam int rsv_w   = data_w - 4 * coord_w - 5;
  localparam int pos_x   = 2;
  localparam int pos_y   = 2;

  // Port indices on every 5-bit link vector
  localparam int n_port = 0;
  localparam int s_port = 1;
  localparam int w_port = 2;
  localparam int e_port = 3;
  localparam int l_port = 4;

  ////////////////////
  // Run length
  ////////////////////
  localparam int reset_cycles    = 10;
  localparam int num_tests       = 6;
  // Sum of the flits sent by tests 2 to 6, 3 + 6 + 10 + 8 + 12
  localparam int total_flits     = 39;
  localparam int cycles_per_flit = 4;
  localparam int test_margin     = 40;
  localparam int watchdog_cycles =
    reset_cycles + 2 * (total_flits * cycles_per_flit + num_tests * test_margin);

  typedef logic [flit_w-1:0] flit_q_t [$];

  logic              clk;
  logic              rst;
  xy_t               position;
  logic [flit_w-1:0] link_data [5];
  logic [4:0]        data_void_i;
  logic [4:0]        stop_i;
  logic [4:0]        data_void_o;
  logic [4:0]        stop_o;
  logic [flit_w-1:0] out_data [5];
  // Flits waiting to be sent on each input
  flit_q_t           staged_q [5];
  // Flits each output still owes in delivery order
  flit_q_t           expected_q [5];
  // Everything the outputs delivered
  flit_q_t           got_q [5];
  int                seen_count [5];
  int                error_count;
  int                test_count;

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  lookahead_router dut_i (
    .clk         (clk),
    .rst         (rst),
    .position_i  (position),
    .data_n_i    (link_data[n_port]),
    .data_s_i    (link_data[s_port]),
    .data_w_i    (link_data[w_port]),
    .data_e_i    (link_data[e_port]),
    .data_p_i    (link_data[l_port]),
    .data_void_i (data_void_i),
    .stop_o      (stop_o),
    .data_n_o    (out_data[n_port]),
    .data_s_o    (out_data[s_port]),
    .data_w_o    (out_data[w_port]),
    .data_e_o    (out_data[e_port]),
    .data_p_o    (out_data[l_port]),
    .data_void_o (data_void_o),
    .stop_i      (stop_i)
  );

  // A flit is delivered on a cycle where the link shows it and is not stopped
  always @(negedge clk) begin
    if (!rst) begin
      for (int p = 0; p < 5; p++) begin
        if (!data_void_o[p] && !stop_i[p]) begin
          got_q[p].push_back(out_data[p]);
        end
      end
    end
  end

  task automatic check_value(input string what, input logic [flit_w-1:0] got,
                             input logic [flit_w-1:0] exp);
    if (got !== exp) begin
      error_count++;
      $display("Mismatch %s: got 0x%h, expected 0x%h", what, got, exp);
    end
  endtask

  `include "tb_router_tasks.svh"

  initial begin
    repeat (watchdog_cycles) @(posedge clk);
    $display("Watchdog expired after %0d cycles, the run did not complete", watchdog_cycles);
    $display(">>> FAIL");
    $finish;
  end

  initial begin
    void'($urandom(46222));
    error_count = 0;
    test_count  = 0;
    rst         = 1'b1;
    position.x  = coord_w'(pos_x);
    position.y  = coord_w'(pos_y);
    data_void_i = '1;
    stop_i      = '0;
    for (int p = 0; p < 5; p++) begin
      link_data[p]  = '0;
      seen_count[p] = 0;
    end
    repeat (reset_cycles) @(posedge clk);
    #0.5;
    rst = 1'b0;

    idle_after_reset();
    single_flit_routing();
    worm_in_order();
    local_contention();
    east_back_pressure();
    crossing_worms();

    $display("Summary: %0d tests run, %0d errors", test_count, error_count);
    if (error_count == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule
